/* src/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// Capture buffer geometry with a depth that is always a power of two
`define CAP_ADDR_BITS 6
`define CAP_DEPTH (1 << `CAP_ADDR_BITS)

// Input sample stream
`define SAMPLE_DATA_W 32
`define SAMPLE_DEST_W 16

// AXI4 write master
`define AXI_ADDR_W 49
`define AXI_DATA_W 128

// Every burst is a full INCR burst of 16-byte beats
`define BURST_BEATS 16
`define BURST_BYTES (`BURST_BEATS * (`AXI_DATA_W / 8))

`endif

/* src/capture_pkg.sv */
`include "capture_params.svh"

package capture_pkg;

    typedef logic [`SAMPLE_DATA_W-1:0] sample_data_t;
    typedef logic [`SAMPLE_DEST_W-1:0] sample_dest_t;
    typedef logic [`CAP_ADDR_BITS-1:0] buf_addr_t;
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;

    // Payload of every sample stream with dest above data
    typedef struct packed {
        sample_dest_t dest;
        sample_data_t data;
    } tagged_sample_t;

    typedef struct packed {
        axi_addr_t addr;
        logic [7:0] len;
    } aw_req_t;

    typedef struct packed {
        axi_data_t data;
        logic last;
    } w_beat_t;

    typedef enum logic [1:0] {
        FILLING,
        ARMED,
        POST_TRIGGER,
        DRAINING
    } buffer_state_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } writer_state_t;

endpackage

/* src/capture_buffer.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_buffer (
    input  logic                       axi_out,
    input  logic                       reset,
    input  logic                       trigger,
    input  capture_pkg::buf_addr_t      trigger_point,
    input  capture_pkg::tagged_sample_t in_sample,
    input  logic                       in_valid,
    output logic                       in_ready,
    output capture_pkg::tagged_sample_t buf_sample,
    output logic                       buf_valid,
    input  logic                       buf_ready,
    output logic                       full,
    input  logic                       rearm
);

    localparam logic [`CAP_ADDR_BITS:0] cap_depth = `CAP_DEPTH;

    capture_pkg::buffer_state_t state;
    capture_pkg::tagged_sample_t mem [`CAP_DEPTH];

    logic                     started;
    capture_pkg::buf_addr_t   wr_ptr;
    capture_pkg::buf_addr_t   fill_cnt;
    capture_pkg::buf_addr_t   rd_addr;
    logic [`CAP_ADDR_BITS:0]  post_cnt;
    logic [`CAP_ADDR_BITS:0]  post_target;
    logic [`CAP_ADDR_BITS:0]  rd_cnt;
    logic                     accept;
    logic                     counting;
    logic                     load;

    // Input is closed for the first cycle after reset and during readout
    assign in_ready = started && (state != capture_pkg::DRAINING);
    assign accept = in_valid && in_ready;
    assign full = (state == capture_pkg::DRAINING);

    // Post-trigger samples fill whatever the pre-trigger history leaves free
    assign post_target = cap_depth - {1'b0, trigger_point};
    assign counting = (state == capture_pkg::POST_TRIGGER) ||
                      (state == capture_pkg::ARMED && trigger);

    // Once full, the write pointer points at the oldest sample
    assign rd_addr = wr_ptr + rd_cnt[`CAP_ADDR_BITS-1:0];
    assign load = (state == capture_pkg::DRAINING) && (rd_cnt != cap_depth) &&
                  (!buf_valid || buf_ready);

    always_ff @(posedge axi_out) begin
        if (reset) begin
            state <= capture_pkg::FILLING;
            started <= 1'b0;
            wr_ptr <= '0;
            fill_cnt <= '0;
            post_cnt <= '0;
            rd_cnt <= '0;
            buf_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (rearm) begin
                state <= capture_pkg::FILLING;
                wr_ptr <= '0;
                fill_cnt <= '0;
                post_cnt <= '0;
                rd_cnt <= '0;
                buf_valid <= 1'b0;
            end else begin
                if (accept) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                case (state)
                    capture_pkg::FILLING: begin
                        if (accept) begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                        // Arm as soon as the pre-trigger history is complete
                        if (trigger_point == '0 ||
                                (accept && fill_cnt + 1'b1 == trigger_point)) begin
                            state <= capture_pkg::ARMED;
                        end
                    end
                    capture_pkg::ARMED, capture_pkg::POST_TRIGGER: begin
                        if (counting) begin
                            state <= capture_pkg::POST_TRIGGER;
                            if (accept) begin
                                post_cnt <= post_cnt + 1'b1;
                                if (post_cnt + 1'b1 == post_target) begin
                                    state <= capture_pkg::DRAINING;
                                end
                            end
                        end
                    end
                    default: begin
                        if (load) begin
                            rd_cnt <= rd_cnt + 1'b1;
                            buf_valid <= 1'b1;
                        end else if (buf_ready) begin
                            buf_valid <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge axi_out) begin
        if (accept) begin
            mem[wr_ptr] <= in_sample;
        end
        if (load) begin
            buf_sample <= mem[rd_addr];
        end
    end

    // Readout never overlaps capture or the rearm that follows it
    a_valid_only_draining: assert property (@(posedge axi_out) disable iff (reset)
        buf_valid |-> state == capture_pkg::DRAINING);

endmodule

/* src/beat_packer.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module beat_packer (
    input  logic                       axi_out,
    input  logic                       reset,
    input  capture_pkg::tagged_sample_t buf_sample,
    input  logic                       buf_valid,
    output logic                       buf_ready,
    output capture_pkg::axi_data_t      beat,
    output logic                       beat_valid,
    input  logic                       beat_ready
);

    localparam int half_w = `AXI_DATA_W / 2;
    localparam int tag_w = half_w - `SAMPLE_DATA_W;

    capture_pkg::tagged_sample_t first;
    logic have_first;
    logic accept;

    // Each half of a beat is the tag zero-extended above the sample value
    function automatic logic [half_w-1:0] pack_half(capture_pkg::tagged_sample_t s);
        return {tag_w'(s.dest), s.data};
    endfunction

    // Intake waits while a finished beat is still pending
    assign buf_ready = !beat_valid;
    assign accept = buf_valid && buf_ready;

    always_ff @(posedge axi_out) begin
        if (reset) begin
            have_first <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            if (beat_valid && beat_ready) begin
                beat_valid <= 1'b0;
            end
            if (accept) begin
                have_first <= !have_first;
                if (have_first) begin
                    beat_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axi_out) begin
        if (accept && !have_first) begin
            first <= buf_sample;
        end
        // Earlier sample goes to the low half
        if (accept && have_first) begin
            beat <= {pack_half(buf_sample), pack_half(first)};
        end
    end

    a_beat_stable: assert property (@(posedge axi_out) disable iff (reset)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

/* src/burst_writer.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module burst_writer (
    input  logic                  axi_out,
    input  logic                  reset,
    input  capture_pkg::axi_addr_t dma_base_addr,
    input  capture_pkg::axi_data_t beat,
    input  logic                  beat_valid,
    output logic                  beat_ready,
    output capture_pkg::aw_req_t   aw,
    output logic                  awvalid,
    input  logic                  awready,
    output capture_pkg::w_beat_t   w,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output logic                  dma_done
);

    localparam logic [7:0] last_beat = 8'(`BURST_BEATS - 1);

    // A beat holds two samples, so the packet is half the buffer depth in beats
    localparam logic [`CAP_ADDR_BITS-1:0] last_burst =
        (`CAP_ADDR_BITS)'(`CAP_DEPTH / 2 / `BURST_BEATS - 1);

    capture_pkg::writer_state_t state;
    capture_pkg::axi_addr_t     cur_addr;
    logic [7:0]                 beat_cnt;
    logic [`CAP_ADDR_BITS-1:0]  burst_cnt;
    logic                       w_fire;
    logic                       b_fire;

    assign awvalid = (state == capture_pkg::ADDR);
    assign aw = '{addr: cur_addr, len: last_beat};

    // W follows the packer directly and the packer's hold rule keeps the payload stable
    assign wvalid = (state == capture_pkg::DATA) && beat_valid;
    assign beat_ready = (state == capture_pkg::DATA) && wready;
    assign w = '{data: beat, last: (beat_cnt == last_beat)};

    assign bready = (state == capture_pkg::RESP);

    assign w_fire = wvalid && wready;
    assign b_fire = bvalid && bready;

    always_ff @(posedge axi_out) begin
        if (reset) begin
            state <= capture_pkg::IDLE;
            beat_cnt <= '0;
            burst_cnt <= '0;
            dma_done <= 1'b0;
        end else begin
            dma_done <= b_fire && (burst_cnt == last_burst);
            case (state)
                capture_pkg::IDLE: begin
                    if (beat_valid) begin
                        state <= capture_pkg::ADDR;
                    end
                end
                capture_pkg::ADDR: begin
                    if (awready) begin
                        beat_cnt <= '0;
                        state <= capture_pkg::DATA;
                    end
                end
                capture_pkg::DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == last_beat) begin
                            state <= capture_pkg::RESP;
                        end
                    end
                end
                default: begin
                    if (b_fire) begin
                        state <= capture_pkg::IDLE;
                        if (burst_cnt == last_burst) begin
                            burst_cnt <= '0;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // The burst address is an AW payload, so it only moves outside ADDR
    always_ff @(posedge axi_out) begin
        if (state == capture_pkg::IDLE && burst_cnt == '0) begin
            cur_addr <= dma_base_addr;
        end else if (b_fire) begin
            cur_addr <= cur_addr + capture_pkg::axi_addr_t'(`BURST_BYTES);
        end
    end

    a_aw_hold: assert property (@(posedge axi_out) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(aw));

endmodule

/* src/capture_dma_top.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_dma_top (
    input  logic                        axi_out,
    input  logic                        reset,
    input  logic                        trigger,
    input  capture_pkg::buf_addr_t       trigger_point,
    input  capture_pkg::axi_addr_t       dma_base_addr,
    input  capture_pkg::tagged_sample_t  in_sample,
    input  logic                        in_valid,
    output logic                        in_ready,
    output capture_pkg::axi_addr_t       awaddr,
    output logic [7:0]                  awlen,
    output logic                        awvalid,
    input  logic                        awready,
    output capture_pkg::axi_data_t       wdata,
    output logic                        wlast,
    output logic [`AXI_DATA_W/8-1:0]    wstrb,
    output logic                        wvalid,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        bready,
    output logic                        full,
    output logic                        dma_done
);

    capture_pkg::tagged_sample_t buf_sample;
    logic                       buf_valid;
    logic                       buf_ready;
    capture_pkg::axi_data_t      beat;
    logic                       beat_valid;
    logic                       beat_ready;
    capture_pkg::aw_req_t        aw;
    capture_pkg::w_beat_t        w;

    // Bursts are always 16-byte INCR beats with every byte lane written
    assign awaddr = aw.addr;
    assign awlen = aw.len;
    assign wdata = w.data;
    assign wlast = w.last;
    assign wstrb = '1;

    capture_buffer u_buffer (
        .axi_out(axi_out), .reset(reset), .trigger(trigger),
        .trigger_point(trigger_point), .in_sample(in_sample), .in_valid(in_valid),
        .in_ready(in_ready), .buf_sample(buf_sample), .buf_valid(buf_valid),
        .buf_ready(buf_ready), .full(full), .rearm(dma_done)
    );

    beat_packer u_packer (
        .axi_out(axi_out), .reset(reset), .buf_sample(buf_sample),
        .buf_valid(buf_valid), .buf_ready(buf_ready), .beat(beat),
        .beat_valid(beat_valid), .beat_ready(beat_ready)
    );

    burst_writer u_writer (
        .axi_out(axi_out), .reset(reset), .dma_base_addr(dma_base_addr),
        .beat(beat), .beat_valid(beat_valid), .beat_ready(beat_ready),
        .aw(aw), .awvalid(awvalid), .awready(awready), .w(w), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready), .dma_done(dma_done)
    );

endmodule

/* testbench/capture_dma_tb.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_dma_tb;

    localparam int depth = `CAP_DEPTH;
    localparam int packet_beats = `CAP_DEPTH / 2;
    localparam int packet_bursts = packet_beats / `BURST_BEATS;
    localparam int half_w = `AXI_DATA_W / 2;
    localparam int max_tests = 16;

    logic                        axi_out;
    logic                        reset;
    logic                        trigger;
    capture_pkg::buf_addr_t      trigger_point;
    capture_pkg::axi_addr_t      dma_base_addr;
    capture_pkg::tagged_sample_t in_sample;
    logic                        in_valid;
    logic                        in_ready;
    capture_pkg::axi_addr_t      awaddr;
    logic [7:0]                  awlen;
    logic                        awvalid;
    logic                        awready;
    capture_pkg::axi_data_t      wdata;
    logic                        wlast;
    logic [`AXI_DATA_W/8-1:0]    wstrb;
    logic                        wvalid;
    logic                        wready;
    logic                        bvalid;
    logic                        bready;
    logic                        full;
    logic                        dma_done;

    // Golden table with one entry per test
    string                  test_names [max_tests];
    int                     tp_list [max_tests];
    int                     pre_list [max_tests];
    capture_pkg::axi_addr_t base_list [max_tests];
    int                     first_list [max_tests];
    int                     n_tests;

    // State of the test in progress
    string                  test_name;
    capture_pkg::axi_addr_t cur_base;
    int                     first_idx;
    int                     pre_count;
    int                     sent;
    int                     aw_count;
    int                     w_count;
    int                     b_count;
    int                     b_pending;
    logic                   seen_ready;
    logic                   capture_over;
    logic                   done_seen;
    logic                   last_b_fired;
    logic                   b_fired;
    int                     cycles;
    int                     cycle_limit;

    capture_dma_top uut (
        .axi_out(axi_out), .reset(reset), .trigger(trigger),
        .trigger_point(trigger_point), .dma_base_addr(dma_base_addr),
        .in_sample(in_sample), .in_valid(in_valid), .in_ready(in_ready),
        .awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wstrb(wstrb), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready), .full(full),
        .dma_done(dma_done)
    );

    initial begin
        axi_out = 1'b0;
        forever begin
            #2 axi_out = ~axi_out;
        end
    end

    always @(posedge axi_out) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // Sample i carries data i and the tag i+1000
    function automatic capture_pkg::tagged_sample_t sample_at(int i);
        capture_pkg::tagged_sample_t s;
        s.data = `SAMPLE_DATA_W'(i);
        s.dest = `SAMPLE_DEST_W'(i + 1000);
        return s;
    endfunction

    function automatic logic [half_w-1:0] half_of(int i);
        logic [half_w-1:0] h;
        h = '0;
        h[`SAMPLE_DATA_W-1:0] = `SAMPLE_DATA_W'(i);
        h[`SAMPLE_DATA_W +: `SAMPLE_DEST_W] = `SAMPLE_DEST_W'(i + 1000);
        return h;
    endfunction

    // Earlier sample of the pair sits in the low half
    function automatic capture_pkg::axi_data_t expected_beat(int j);
        return {half_of(j + 1), half_of(j)};
    endfunction

    task automatic check_value(input string what, input logic [`AXI_DATA_W-1:0] expected,
            input logic [`AXI_DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("error: test %0s, %0s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic read_golden();
        int fd;
        int count;
        string line;
        string name;
        int tp;
        int pre;
        capture_pkg::axi_addr_t base;
        int first;
        n_tests = 0;
        fd = $fopen("testbench/capture_dma_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file testbench/capture_dma_golden.txt");
            $display("RESULT: FAIL");
            $fatal(1);
        end
        while (!$feof(fd) && n_tests < max_tests) begin
            count = $fgets(line, fd);
            if (count > 0 && line.getc(0) != "#") begin
                count = $sscanf(line, "%s %d %d %h %d", name, tp, pre, base, first);
                if (count == 5) begin
                    test_names[n_tests] = name;
                    tp_list[n_tests] = tp;
                    pre_list[n_tests] = pre;
                    base_list[n_tests] = base;
                    first_list[n_tests] = first;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("The golden file holds no test lines");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Looks at the settled signals in mid cycle, so these are the handshakes of the next edge
    task automatic observe_cycle();
        check_value("dma_done", last_b_fired, dma_done);
        if (dma_done) begin
            done_seen = 1'b1;
            check_value("beats per packet", packet_beats, w_count);
            check_value("bursts per packet", packet_bursts, aw_count);
        end
        if (in_valid && in_ready) begin
            if (sent >= first_idx + depth) begin
                check_value("samples accepted", first_idx + depth, sent + 1);
            end
            sent++;
            seen_ready = 1'b1;
        end else if (!in_ready && seen_ready && !capture_over) begin
            capture_over = 1'b1;
            check_value("samples before in_ready drop", first_idx + depth, sent);
        end
        check_value("full", capture_over, full);
        // The writer only takes a response while a finished burst waits for it
        check_value("bready", b_pending > 0, bready);
        if (awvalid && awready) begin
            check_value("awaddr", cur_base + `BURST_BYTES * aw_count, awaddr);
            check_value("awlen", `BURST_BEATS - 1, awlen);
            aw_count++;
        end
        if (wvalid && wready) begin
            check_value("wdata", expected_beat(first_idx + 2 * w_count), wdata);
            check_value("wlast", (w_count % `BURST_BEATS) == `BURST_BEATS - 1, wlast);
            check_value("wstrb", {(`AXI_DATA_W/8){1'b1}}, wstrb);
            w_count++;
            if (wlast) begin
                b_pending++;
            end
        end
        b_fired = bvalid && bready;
        last_b_fired = 1'b0;
        if (b_fired) begin
            b_count++;
            b_pending--;
            last_b_fired = (b_count == packet_bursts);
        end
    endtask

    task automatic drive_cycle();
        if (!capture_over) begin
            in_valid = 1'b1;
            in_sample = sample_at(sent);
            trigger = (sent >= pre_count);
        end else begin
            in_valid = 1'b0;
            trigger = 1'b0;
        end
        awready = ($urandom % 3) != 0;
        wready = ($urandom % 4) != 0;
        // A raised bvalid stays up until bready takes it
        if (!(bvalid && !b_fired)) begin
            bvalid = (b_pending > 0) && (($urandom % 3) == 0);
        end
    endtask

    task automatic run_test(int idx);
        test_name = test_names[idx];
        first_idx = first_list[idx];
        pre_count = pre_list[idx];
        cur_base = base_list[idx];
        sent = 0;
        aw_count = 0;
        w_count = 0;
        b_count = 0;
        b_pending = 0;
        seen_ready = 1'b0;
        capture_over = 1'b0;
        done_seen = 1'b0;
        last_b_fired = 1'b0;
        b_fired = 1'b0;
        @(posedge axi_out);
        #1;
        trigger_point = capture_pkg::buf_addr_t'(tp_list[idx]);
        dma_base_addr = cur_base;
        drive_cycle();
        while (!done_seen) begin
            @(negedge axi_out);
            observe_cycle();
            if (!done_seen) begin
                @(posedge axi_out);
                #1;
                drive_cycle();
            end
        end
        $display("Test %0s finished, %0d samples sent, %0d beats written",
                 test_name, sent, w_count);
    endtask

    initial begin
        reset = 1'b1;
        trigger = 1'b0;
        trigger_point = '0;
        dma_base_addr = '0;
        in_sample = '0;
        in_valid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        cycles = 0;
        cycle_limit = 0;
        void'($urandom(32'h6653cc5d));
        read_golden();
        cycle_limit = n_tests * 2000;
        repeat (16) @(posedge axi_out);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* testbench/capture_dma_golden.txt */
# Columns: test name, trigger point, samples sent before trigger,
# base address in hex, expected index of the first captured sample
# Samples are numbered from zero in every test, data i and dest i+1000
# A trigger sent before the pre-trigger history exists acts at sample trigger point
mid_trigger      32   40  0000000010000    8
early_trigger    16    4  0100000000000    0
max_history      63   70  0000000abc000    7
min_history       1    1  0000000002000    0
no_history        0    5  1ffffffff0000    5
late_trigger      8  150  0000000040000  142
history_edge     20   20  00000dead0000    0
long_wait        48   10  0000000100000    0

/* files.f */
+incdir+src
src/capture_pkg.sv
src/capture_buffer.sv
src/beat_packer.sv
src/burst_writer.sv
src/capture_dma_top.sv
testbench/capture_dma_tb.sv
